/* common/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_LEN_W  = 4;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // bytes per beat, log2 encoded
    typedef enum logic [2:0] {
        SIZE_1B = 3'b000,
        SIZE_2B = 3'b001,
        SIZE_4B = 3'b010
    } axi_size_e;

    // one id per requester so R beats can be steered back
    typedef enum logic [3:0] {
        ID_ICACHE   = 4'd0,
        ID_UNCACHED = 4'd1
    } axi_id_e;

endpackage

`default_nettype wire

/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // 16-byte lines, four 32-bit words
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;
    localparam int LINE_W     = LINE_WORDS * 32;

    localparam logic [3:0] REFILL_LEN = 4'd3; // arlen is beats - 1

    typedef enum logic [1:0] {
        IC_IDLE   = 2'd0,
        IC_MISS   = 2'd1,
        IC_REFILL = 2'd2
    } icache_state_e;

    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_ADDR = 2'd1,
        BR_DATA = 2'd2
    } bridge_state_e;

endpackage

`default_nettype wire

/* icache/icache.sv */
`default_nettype none
`timescale 1ns/100ps

module icache #(
    parameter int INDEX_W = 8
) (
    input  logic                          aclk,
    input  logic                          rst_n,

    input  logic                          fetch_valid,
    input  logic [31:0]                   fetch_addr,
    output logic                          fetch_ready,
    output logic                          fetch_rvalid,
    output logic [31:0]                   fetch_rdata,

    output logic                          refill_req,
    output logic [31:0]                   refill_addr,
    input  logic                          refill_ready,
    input  logic                          refill_valid,
    input  logic [icache_pkg::LINE_W-1:0] refill_data
);

    import icache_pkg::*;

    localparam int SETS       = 2 ** INDEX_W;
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

    icache_state_e state;
    icache_state_e state_nxt;

    logic [LINE_W-1:0] data_arr [SETS];
    logic [TAG_W-1:0]  tag_arr  [SETS];
    logic [SETS-1:0]   valid_q;

    // address of the request under lookup
    logic [31:0]           req_addr;
    logic                  req_pending;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_index;
    logic [WORD_SEL_W-1:0] req_word;

    logic              lookup;
    logic              hit;
    logic              fill_en;
    logic [LINE_W-1:0] rd_line;

    assign req_tag   = req_addr[31 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_addr[OFFSET_W-1 -: WORD_SEL_W];

    assign lookup  = (state == IC_IDLE) && req_pending;
    assign hit     = valid_q[req_index] && (tag_arr[req_index] == req_tag);
    assign fill_en = (state == IC_REFILL) && refill_valid;
    assign rd_line = data_arr[req_index];

    // after a fill the same address is looked up again and hits
    assign fetch_rvalid = lookup && hit;
    assign fetch_rdata  = rd_line[req_word * 32 +: 32];
    assign fetch_ready  = (state == IC_IDLE) && (!req_pending || hit);

    assign refill_req  = (state == IC_MISS);
    assign refill_addr = {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}}; // line aligned

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            req_pending <= 1'b0;
        end else if (fetch_ready) begin
            req_pending <= fetch_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (fetch_valid && fetch_ready) begin
            req_addr <= fetch_addr;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IC_IDLE: begin
                if (lookup && !hit) begin
                    state_nxt = IC_MISS;
                end
            end
            IC_MISS: begin
                if (refill_ready) begin
                    state_nxt = IC_REFILL;
                end
            end
            IC_REFILL: begin
                if (refill_valid) begin
                    state_nxt = IC_IDLE;
                end
            end
            default: state_nxt = IC_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IC_IDLE;
            valid_q <= '0;
        end else begin
            state <= state_nxt;
            if (fill_en) begin
                valid_q[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (fill_en) begin
            data_arr[req_index] <= refill_data;
            tag_arr[req_index]  <= req_tag;
        end
    end

    // no new fetch while a line is outstanding
    assert property (@(posedge aclk) disable iff (!rst_n)
        (state == IC_MISS || state == IC_REFILL) |-> !fetch_ready);

    // bridge must not return a line nobody asked for
    assert property (@(posedge aclk) disable iff (!rst_n)
        refill_valid |-> (state == IC_REFILL));

endmodule

`default_nettype wire

/* logic/axi_read_bridge.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_read_bridge (
    input  logic                              aclk,
    input  logic                              rst_n,

    input  logic                              refill_req,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    refill_addr,
    output logic                              refill_ready,
    output logic                              refill_valid,
    output logic [icache_pkg::LINE_W-1:0]     refill_data,

    input  logic                              ucd_req,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    ucd_addr,
    input  axi_pkg::axi_size_e                ucd_size,
    output logic                              ucd_ready,
    output logic                              ucd_ret_valid,
    output logic [axi_pkg::AXI_DATA_W-1:0]    ucd_ret_data,

    output axi_pkg::axi_id_e                  arid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    araddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]     arlen,
    output axi_pkg::axi_size_e                arsize,
    output axi_pkg::axi_burst_e               arburst,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      rid,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready
);

    import axi_pkg::*;
    import icache_pkg::*;

    bridge_state_e state;
    bridge_state_e state_nxt;

    // fields of the read in flight
    axi_id_e                cur_id;
    logic [AXI_ADDR_W-1:0]  cur_addr;
    logic [AXI_LEN_W-1:0]   cur_len;
    axi_size_e              cur_size;

    logic [LINE_W-1:0]      line_buf;
    logic [AXI_LEN_W-1:0]   beat_cnt;

    logic ucd_take;
    logic refill_take;
    logic beat;

    // uncached wins when both ask in the same cycle
    assign ucd_ready    = (state == BR_IDLE);
    assign refill_ready = (state == BR_IDLE) && !ucd_req;
    assign ucd_take     = ucd_req && ucd_ready;
    assign refill_take  = refill_req && refill_ready;

    assign arvalid = (state == BR_ADDR);
    assign arid    = cur_id;
    assign araddr  = cur_addr;
    assign arlen   = cur_len;
    assign arsize  = cur_size;
    assign arburst = BURST_INCR;

    assign rready = (state == BR_DATA);
    assign beat   = rready && rvalid;

    assign refill_data  = line_buf;
    assign ucd_ret_data = line_buf[LINE_W-1 -: AXI_DATA_W]; // last beat lands on top

    always_ff @(posedge aclk) begin
        if (ucd_take) begin
            cur_id   <= ID_UNCACHED;
            cur_addr <= ucd_addr;
            cur_len  <= '0;
            cur_size <= ucd_size;
        end else if (refill_take) begin
            cur_id   <= ID_ICACHE;
            cur_addr <= refill_addr;
            cur_len  <= REFILL_LEN;
            cur_size <= SIZE_4B;
        end
        if (beat) begin
            line_buf <= {rdata, line_buf[LINE_W-1:AXI_DATA_W]};
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            BR_IDLE: begin
                if (ucd_take || refill_take) begin
                    state_nxt = BR_ADDR;
                end
            end
            BR_ADDR: begin
                if (arready) begin
                    state_nxt = BR_DATA;
                end
            end
            BR_DATA: begin
                if (beat && rlast) begin
                    state_nxt = BR_IDLE;
                end
            end
            default: state_nxt = BR_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= BR_IDLE;
            beat_cnt      <= '0;
            refill_valid  <= 1'b0;
            ucd_ret_valid <= 1'b0;
        end else begin
            state         <= state_nxt;
            refill_valid  <= beat && rlast && (cur_id == ID_ICACHE);
            ucd_ret_valid <= beat && rlast && (cur_id == ID_UNCACHED);
            if (arvalid && arready) begin
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n)
        (arvalid && !arready) |=> arvalid && $stable(arid) && $stable(araddr)
            && $stable(arlen) && $stable(arsize) && $stable(arburst));

    // single outstanding read, so every beat belongs to it
    assert property (@(posedge aclk) disable iff (!rst_n)
        (state == BR_DATA && rvalid) |-> (rid == cur_id));

    assert property (@(posedge aclk) disable iff (!rst_n)
        (state == BR_DATA && rvalid) |-> (rlast == (beat_cnt == cur_len)));

endmodule

`default_nettype wire

/* logic/mem_subsys_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter int INDEX_W = 8
) (
    input  logic                           aclk,
    input  logic                           rst_n,

    input  logic                           fetch_valid,
    input  logic [31:0]                    fetch_addr,
    output logic                           fetch_ready,
    output logic                           fetch_rvalid,
    output logic [31:0]                    fetch_rdata,

    input  logic                           ucd_req,
    input  logic [31:0]                    ucd_addr,
    input  axi_pkg::axi_size_e             ucd_size,
    output logic                           ucd_ready,
    output logic                           ucd_ret_valid,
    output logic [31:0]                    ucd_ret_data,

    output axi_pkg::axi_id_e               arid,
    output logic [axi_pkg::AXI_ADDR_W-1:0] araddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]  arlen,
    output axi_pkg::axi_size_e             arsize,
    output axi_pkg::axi_burst_e            arburst,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [axi_pkg::AXI_ID_W-1:0]   rid,
    input  logic [axi_pkg::AXI_DATA_W-1:0] rdata,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready
);

    import icache_pkg::*;

    // cache line refill channel
    logic              refill_req;
    logic [31:0]       refill_addr;
    logic              refill_ready;
    logic              refill_valid;
    logic [LINE_W-1:0] refill_data;

    icache #(
        .INDEX_W (INDEX_W)
    ) icache_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_ready  (fetch_ready),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_ready (refill_ready),
        .refill_valid (refill_valid),
        .refill_data  (refill_data)
    );

    axi_read_bridge axi_read_bridge_i (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .refill_req    (refill_req),
        .refill_addr   (refill_addr),
        .refill_ready  (refill_ready),
        .refill_valid  (refill_valid),
        .refill_data   (refill_data),
        .ucd_req       (ucd_req),
        .ucd_addr      (ucd_addr),
        .ucd_size      (ucd_size),
        .ucd_ready     (ucd_ready),
        .ucd_ret_valid (ucd_ret_valid),
        .ucd_ret_data  (ucd_ret_data),
        .arid          (arid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arvalid       (arvalid),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready)
    );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_mem_model (
    input  logic                aclk,
    input  logic                rst_n,
    input  axi_pkg::axi_id_e    arid,
    input  logic [31:0]         araddr,
    input  logic [3:0]          arlen,
    input  axi_pkg::axi_size_e  arsize,
    input  axi_pkg::axi_burst_e arburst,
    input  logic                arvalid,
    output logic                arready,
    output logic [3:0]          rid,
    output logic [31:0]         rdata,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,
    output int                  ar_count
);

    import axi_pkg::*;

    localparam int LOG_DEPTH     = 64;
    localparam int READY_TIMEOUT = 64;

    // one entry per AR handshake
    axi_id_e     ar_id_log    [LOG_DEPTH];
    logic [31:0] ar_addr_log  [LOG_DEPTH];
    logic [3:0]  ar_len_log   [LOG_DEPTH];
    axi_size_e   ar_size_log  [LOG_DEPTH];
    axi_burst_e  ar_burst_log [LOG_DEPTH];

    integer      seed = 32'h6b73;
    int          delay;
    int          last_beat;
    int          wait_cnt;
    logic [3:0]  cur_id;
    logic [31:0] cur_addr;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return ~{addr[31:2], 2'b00};
    endfunction

    initial begin
        arready  = 1'b0;
        rvalid   = 1'b0;
        rlast    = 1'b0;
        rid      = '0;
        rdata    = '0;
        ar_count = 0;
        forever begin
            @(negedge aclk);
            if (rst_n && arvalid) begin
                delay = $random(seed) & 3; // 0 to 3 cycles of ar back-pressure
                repeat (delay) @(negedge aclk);
                arready = 1'b1;
                if (ar_count < LOG_DEPTH) begin
                    ar_id_log[ar_count]    = arid;
                    ar_addr_log[ar_count]  = araddr;
                    ar_len_log[ar_count]   = arlen;
                    ar_size_log[ar_count]  = arsize;
                    ar_burst_log[ar_count] = arburst;
                end
                cur_id    = arid;
                cur_addr  = araddr;
                last_beat = {28'd0, arlen};
                ar_count++;
                @(negedge aclk);
                arready = 1'b0;
                for (int i = 0; i <= last_beat; i++) begin
                    rvalid = 1'b1;
                    rid    = cur_id;
                    rdata  = word_at(cur_addr + i * 4);
                    rlast  = (i == last_beat);
                    wait_cnt = 0;
                    // beat is held until the bridge takes it
                    while (!rready && wait_cnt < READY_TIMEOUT) begin
                        @(negedge aclk);
                        wait_cnt++;
                    end
                    @(negedge aclk);
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/mem_subsys_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_tb;

    import axi_pkg::*;

    localparam int INDEX_W    = 4;
    localparam int TIMEOUT    = 200;
    localparam int NUM_ROWS   = 10;
    localparam int KIND_FETCH = 0;
    localparam int KIND_UCD   = 1;
    localparam int KIND_BOTH  = 2;

    logic        aclk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic        fetch_rvalid;
    logic [31:0] fetch_rdata;
    logic        ucd_req;
    logic [31:0] ucd_addr;
    axi_size_e   ucd_size;
    logic        ucd_ready;
    logic        ucd_ret_valid;
    logic [31:0] ucd_ret_data;
    axi_id_e     arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    axi_size_e   arsize;
    axi_burst_e  arburst;
    logic        arvalid;
    logic        arready;
    logic [3:0]  rid;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    int          ar_count;

    // stimulus table
    string       row_name   [NUM_ROWS];
    int          row_kind   [NUM_ROWS];
    logic [31:0] row_faddr  [NUM_ROWS];
    logic [31:0] row_uaddr  [NUM_ROWS];
    axi_size_e   row_size   [NUM_ROWS];
    logic [31:0] row_fdata  [NUM_ROWS];
    logic [31:0] row_udata  [NUM_ROWS];
    int          row_new_ar [NUM_ROWS];
    logic [3:0]  row_arlen  [NUM_ROWS];

    logic [31:0] fetch_result;
    int          fetch_latency; // cycles after the one following acceptance
    logic [31:0] ucd_result;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    bit          timed_out = 1'b0;
    integer      seed = 32'h6b73;

    mem_subsys_top #(.INDEX_W(INDEX_W)) mem_subsys_top_i (.*);

    axi_mem_model axi_mem_model_i (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return ~{addr[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] line_base(input logic [31:0] addr);
        return {addr[31:4], 4'h0};
    endfunction

    task automatic set_row(input int i, input string name, input int kind,
                           input logic [31:0] faddr, input logic [31:0] uaddr,
                           input axi_size_e size, input int new_ar, input logic [3:0] len);
        row_name[i]   = name;
        row_kind[i]   = kind;
        row_faddr[i]  = faddr;
        row_uaddr[i]  = uaddr;
        row_size[i]   = size;
        row_fdata[i]  = mem_word(faddr);
        row_udata[i]  = mem_word(uaddr);
        row_new_ar[i] = new_ar;
        row_arlen[i]  = len;
    endtask

    task automatic flag_timeout(input string name, input string what);
        $display("Timeout in %s: %s", name, what);
        timed_out = 1'b1;
        error_count++;
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h", name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_ar(input string name, input int k, input axi_id_e id,
                            input logic [3:0] len, input axi_size_e size,
                            input logic [31:0] addr);
        check_value(name, "arid", 32'(id), 32'(axi_mem_model_i.ar_id_log[k]));
        check_value(name, "arlen", 32'(len), 32'(axi_mem_model_i.ar_len_log[k]));
        check_value(name, "arsize", 32'(size), 32'(axi_mem_model_i.ar_size_log[k]));
        check_value(name, "arburst", 32'(BURST_INCR), 32'(axi_mem_model_i.ar_burst_log[k]));
        check_value(name, "araddr", addr, axi_mem_model_i.ar_addr_log[k]);
    endtask

    task automatic fetch_word(input string name, input logic [31:0] addr);
        int cnt;
        @(negedge aclk);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        cnt = 0;
        while (!fetch_ready && cnt < TIMEOUT) begin
            @(negedge aclk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            flag_timeout(name, "fetch_ready never went high");
        end else begin
            @(negedge aclk); // accepted on the edge just passed
            fetch_valid = 1'b0;
            cnt = 0;
            while (!fetch_rvalid && cnt < TIMEOUT) begin
                @(negedge aclk);
                cnt++;
            end
            if (cnt >= TIMEOUT) begin
                flag_timeout(name, "fetch_rvalid never came");
            end
            fetch_latency = cnt;
            fetch_result  = fetch_rdata;
        end
    endtask

    task automatic ucd_read(input string name, input logic [31:0] addr, input axi_size_e size);
        int cnt;
        @(negedge aclk);
        ucd_req  = 1'b1;
        ucd_addr = addr;
        ucd_size = size;
        cnt = 0;
        while (!ucd_ready && cnt < TIMEOUT) begin
            @(negedge aclk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            flag_timeout(name, "ucd_ready never went high");
        end else begin
            @(negedge aclk);
            ucd_req = 1'b0;
            cnt = 0;
            while (!ucd_ret_valid && cnt < TIMEOUT) begin
                @(negedge aclk);
                cnt++;
            end
            if (cnt >= TIMEOUT) begin
                flag_timeout(name, "ucd_ret_valid never came");
            end
            ucd_result = ucd_ret_data;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_row(input int i);
        int ar_before;
        int errs_before;
        ar_before   = ar_count;
        errs_before = error_count;
        case (row_kind[i])
            KIND_FETCH: fetch_word(row_name[i], row_faddr[i]);
            KIND_UCD:   ucd_read(row_name[i], row_uaddr[i], row_size[i]);
            default: begin
                fork
                    fetch_word(row_name[i], row_faddr[i]);
                    ucd_read(row_name[i], row_uaddr[i], row_size[i]);
                join
            end
        endcase
        if (!timed_out) begin
            if (row_kind[i] != KIND_UCD) begin
                check_value(row_name[i], "fetch data", row_fdata[i], fetch_result);
            end
            if (row_kind[i] != KIND_FETCH) begin
                check_value(row_name[i], "uncached data", row_udata[i], ucd_result);
            end
            if (row_kind[i] == KIND_FETCH && row_new_ar[i] == 0) begin
                check_value(row_name[i], "hit latency", 32'd0, fetch_latency);
            end
            check_value(row_name[i], "AR count", row_new_ar[i], ar_count - ar_before);
            if (ar_count - ar_before == row_new_ar[i] && row_new_ar[i] > 0) begin
                if (row_kind[i] == KIND_FETCH) begin
                    check_ar(row_name[i], ar_before, ID_ICACHE, row_arlen[i], SIZE_4B,
                             line_base(row_faddr[i]));
                end else begin
                    // uncached wins arbitration and the refill follows
                    check_ar(row_name[i], ar_before, ID_UNCACHED, row_arlen[i], row_size[i],
                             row_uaddr[i]);
                end
                if (row_kind[i] == KIND_BOTH) begin
                    check_ar(row_name[i], ar_before + 1, ID_ICACHE, 4'd3, SIZE_4B,
                             line_base(row_faddr[i]));
                end
            end
        end
        report_test(row_name[i], errs_before);
    endtask

    task automatic run_random_fetches();
        logic [31:0] addr;
        int          errs_before;
        errs_before = error_count;
        for (int n = 0; n < 20 && !timed_out; n++) begin
            addr = 32'h0000_5000 + (32'($random(seed)) & 32'h0000_03fc); // 64 lines, 16 sets
            fetch_word("random_fetch", addr);
            if (!timed_out) begin
                check_value("random_fetch", "fetch data", mem_word(addr), fetch_result);
            end
        end
        report_test("random_fetch", errs_before);
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        ucd_req     = 1'b0;
        ucd_addr    = '0;
        ucd_size    = SIZE_4B;
        set_row(0, "cold_miss", KIND_FETCH, 32'h1004, 32'h0, SIZE_4B, 1, 4'd3);
        set_row(1, "line_hit_w0", KIND_FETCH, 32'h1000, 32'h0, SIZE_4B, 0, 4'd0);
        set_row(2, "line_hit_w2", KIND_FETCH, 32'h1008, 32'h0, SIZE_4B, 0, 4'd0);
        set_row(3, "line_hit_w3", KIND_FETCH, 32'h100c, 32'h0, SIZE_4B, 0, 4'd0);
        set_row(4, "conflict_miss", KIND_FETCH, 32'h2004, 32'h0, SIZE_4B, 1, 4'd3);
        set_row(5, "refetch_miss", KIND_FETCH, 32'h1004, 32'h0, SIZE_4B, 1, 4'd3);
        set_row(6, "ucd_word", KIND_UCD, 32'h0, 32'h3000_0040, SIZE_4B, 1, 4'd0);
        set_row(7, "ucd_repeat", KIND_UCD, 32'h0, 32'h3000_0040, SIZE_4B, 1, 4'd0);
        set_row(8, "ucd_half", KIND_UCD, 32'h0, 32'h3000_0046, SIZE_2B, 1, 4'd0);
        set_row(9, "fetch_and_ucd", KIND_BOTH, 32'h4010, 32'h3000_0080, SIZE_4B, 2, 4'd0);
        repeat (8) @(negedge aclk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(i);
        end
        if (!timed_out) begin
            run_random_fetches();
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_subsys_top.f */
common/axi_pkg.sv
common/icache_pkg.sv
icache/icache.sv
logic/axi_read_bridge.sv
logic/mem_subsys_top.sv
dv/axi_mem_model.sv
dv/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, pass only if the testbench reports it
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert --top-module mem_subsys_tb \
    -f mem_subsys_top.f -o mem_subsys_sim 2>&1 && ./obj_dir/mem_subsys_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Regression passed$" && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
